// ==== verilog/lpif_pkg.sv ====
package lpif_pkg;

  //////////////////////////////
  // Flit field widths
  //////////////////////////////

  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int DATA_W   = 64;
  localparam int BVALID_W = 8;

  // Fields plus the single valid bit
  localparam int FLIT_W = STATE_W + PROTID_W + DATA_W + BVALID_W + 1;

  // Field positions, packed from the LSB upward
  localparam int VALID_LSB  = 0;
  localparam int BVALID_LSB = VALID_LSB + 1;
  localparam int DATA_LSB   = BVALID_LSB + BVALID_W;
  localparam int PROTID_LSB = DATA_LSB + DATA_W;
  localparam int STATE_LSB  = PROTID_LSB + PROTID_W;

  //////////////////////////////
  // Lane word layout
  //////////////////////////////

  localparam int LANE_PAYLOAD_W = 22;

  // Payload plus strobe and marker
  localparam int LANE_W  = LANE_PAYLOAD_W + 2;
  localparam int STB_BIT = LANE_PAYLOAD_W;
  localparam int MRK_BIT = LANE_PAYLOAD_W + 1;

  // Fewest lanes that still hold a whole flit
  localparam int MIN_LANES = (FLIT_W + LANE_PAYLOAD_W - 1) / LANE_PAYLOAD_W;

  //////////////////////////////
  // Sync defaults
  //////////////////////////////

  localparam int DELAY_W = 8;

  // Cycles between strobe words
  localparam int STROBE_PERIOD_DEF = 16;

endpackage

// ==== verilog/link_auto_sync.sv ====
`timescale 1ns/10ps

module link_auto_sync #(
  parameter int STROBE_PERIOD = lpif_pkg::STROBE_PERIOD_DEF
) (
  input  logic                         clk_wr,
  input  logic                         rst,

  input  logic                         tx_online,
  input  logic                         rx_online,

  input  logic [lpif_pkg::DELAY_W-1:0] delay_x_value,
  input  logic [lpif_pkg::DELAY_W-1:0] delay_xz_value,
  input  logic [lpif_pkg::DELAY_W-1:0] delay_yz_value,

  output logic                         tx_online_delay,
  output logic                         rx_online_delay,
  output logic                         tx_auto_mrk_userbit,
  output logic                         tx_auto_stb_userbit
);

  import lpif_pkg::*;

  localparam int STB_CNT_W = (STROBE_PERIOD > 1) ? $clog2(STROBE_PERIOD) : 1;
  localparam logic [STB_CNT_W-1:0] STB_LAST = STB_CNT_W'(STROBE_PERIOD - 1);

  // One extra bit so xz plus yz never wraps
  logic [DELAY_W:0]     tx_target;
  logic [DELAY_W:0]     tx_cnt;
  logic                 tx_go;
  logic [DELAY_W-1:0]   rx_cnt;
  logic                 rx_go;
  logic [STB_CNT_W-1:0] stb_cnt;

  assign tx_target = {1'b0, delay_xz_value} + {1'b0, delay_yz_value};
  assign tx_go     = tx_online && (tx_cnt >= tx_target);
  assign rx_go     = rx_online && (rx_cnt >= delay_x_value);

  // Tx side delay, marker and strobe
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_cnt              <= '0;
      tx_online_delay     <= 1'b0;
      tx_auto_mrk_userbit <= 1'b0;
      tx_auto_stb_userbit <= 1'b0;
      stb_cnt             <= '0;
    end else begin
      // Counter holds once the target is reached
      if (!tx_online) begin
        tx_cnt <= '0;
      end else if (!tx_go) begin
        tx_cnt <= tx_cnt + 1'b1;
      end
      tx_online_delay <= tx_go;

      if (!tx_go) begin
        tx_auto_mrk_userbit <= 1'b0;
        tx_auto_stb_userbit <= 1'b0;
        stb_cnt             <= '0;
      end else if (!tx_online_delay) begin
        // First online cycle
        tx_auto_mrk_userbit <= 1'b1;
        tx_auto_stb_userbit <= 1'b1;
        stb_cnt             <= '0;
      end else begin
        tx_auto_mrk_userbit <= ~tx_auto_mrk_userbit;
        if (stb_cnt == STB_LAST) begin
          tx_auto_stb_userbit <= 1'b1;
          stb_cnt             <= '0;
        end else begin
          tx_auto_stb_userbit <= 1'b0;
          stb_cnt             <= stb_cnt + 1'b1;
        end
      end
    end
  end

  // Rx side delay
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else begin
      if (!rx_online) begin
        rx_cnt <= '0;
      end else if (!rx_go) begin
        rx_cnt <= rx_cnt + 1'b1;
      end
      rx_online_delay <= rx_go;
    end
  end

  a_tx_rise_online: assert property (@(posedge clk_wr) disable iff (rst)
    $rose(tx_online_delay) |-> $past(tx_online));

  a_rx_rise_online: assert property (@(posedge clk_wr) disable iff (rst)
    $rose(rx_online_delay) |-> $past(rx_online));

  a_stb_online: assert property (@(posedge clk_wr) disable iff (rst)
    $rose(tx_auto_stb_userbit) |-> tx_online_delay);

endmodule

// ==== verilog/lpif_tx_lane_packer.sv ====
`timescale 1ns/10ps

module lpif_tx_lane_packer #(
  parameter int NUM_LANES = 4
) (
  input  logic                                  clk_wr,
  input  logic                                  rst,

  input  logic                                  tx_online_delay,
  input  logic                                  tx_mrk_userbit,
  input  logic                                  tx_stb_userbit,

  // Upstream flit
  input  logic [lpif_pkg::STATE_W-1:0]          ustrm_state,
  input  logic [lpif_pkg::PROTID_W-1:0]         ustrm_protid,
  input  logic [lpif_pkg::DATA_W-1:0]           ustrm_data,
  input  logic [lpif_pkg::BVALID_W-1:0]         ustrm_bvalid,
  input  logic                                  ustrm_valid,

  output logic [NUM_LANES*lpif_pkg::LANE_W-1:0] tx_phy
);

  import lpif_pkg::*;

  localparam int PAD_W = NUM_LANES * LANE_PAYLOAD_W;

  logic [FLIT_W-1:0]           flit;
  logic [PAD_W-1:0]            flit_pad;
  logic [NUM_LANES*LANE_W-1:0] phy_nxt;
  logic [NUM_LANES-1:0]        lane_mrk;

  if (NUM_LANES < MIN_LANES) begin : g_lane_check
    $error("NUM_LANES too small to carry one flit");
  end

  // Valid at the LSB, state at the top
  assign flit     = {ustrm_state, ustrm_protid, ustrm_data, ustrm_bvalid, ustrm_valid};
  assign flit_pad = PAD_W'(flit);

  //////////////////////////////
  // Lane slicing
  //////////////////////////////

  always_comb begin
    phy_nxt = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      phy_nxt[k*LANE_W +: LANE_PAYLOAD_W] = flit_pad[k*LANE_PAYLOAD_W +: LANE_PAYLOAD_W];
      // Same marker and strobe on every lane
      phy_nxt[k*LANE_W + STB_BIT] = tx_stb_userbit;
      phy_nxt[k*LANE_W + MRK_BIT] = tx_mrk_userbit;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy <= '0;
    end else if (!tx_online_delay) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= phy_nxt;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      lane_mrk[k] = tx_phy[k*LANE_W + MRK_BIT];
    end
  end

  // All lanes carry one marker value
  a_mrk_lanes_equal: assert property (@(posedge clk_wr) disable iff (rst)
    (lane_mrk == '0) || (lane_mrk == '1));

endmodule

// ==== verilog/lpif_rx_lane_unpacker.sv ====
`timescale 1ns/10ps

module lpif_rx_lane_unpacker #(
  parameter int NUM_LANES = 4
) (
  input  logic                                  clk_wr,
  input  logic                                  rst,

  input  logic                                  rx_online_delay,
  input  logic [NUM_LANES*lpif_pkg::LANE_W-1:0] rx_phy,

  // Downstream flit
  output logic [lpif_pkg::STATE_W-1:0]          dstrm_state,
  output logic [lpif_pkg::PROTID_W-1:0]         dstrm_protid,
  output logic [lpif_pkg::DATA_W-1:0]           dstrm_data,
  output logic [lpif_pkg::BVALID_W-1:0]         dstrm_bvalid,
  output logic                                  dstrm_valid
);

  import lpif_pkg::*;

  localparam int PAD_W = NUM_LANES * LANE_PAYLOAD_W;

  logic [PAD_W-1:0]     rx_flit_pad;
  logic [FLIT_W-1:0]    rx_flit;
  logic [NUM_LANES-1:0] lane_mrk;
  logic [NUM_LANES-1:0] lane_stb;

  //////////////////////////////
  // Lane reassembly
  //////////////////////////////

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      rx_flit_pad[k*LANE_PAYLOAD_W +: LANE_PAYLOAD_W] = rx_phy[k*LANE_W +: LANE_PAYLOAD_W];
      lane_mrk[k] = rx_phy[k*LANE_W + MRK_BIT];
      lane_stb[k] = rx_phy[k*LANE_W + STB_BIT];
    end
  end

  // Padding above the flit is dropped
  assign rx_flit = rx_flit_pad[FLIT_W-1:0];

  // Output stage, zero while offline
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      dstrm_state  <= '0;
      dstrm_protid <= '0;
      dstrm_data   <= '0;
      dstrm_bvalid <= '0;
      dstrm_valid  <= 1'b0;
    end else if (!rx_online_delay) begin
      dstrm_state  <= '0;
      dstrm_protid <= '0;
      dstrm_data   <= '0;
      dstrm_bvalid <= '0;
      dstrm_valid  <= 1'b0;
    end else begin
      dstrm_state  <= rx_flit[STATE_LSB +: STATE_W];
      dstrm_protid <= rx_flit[PROTID_LSB +: PROTID_W];
      dstrm_data   <= rx_flit[DATA_LSB +: DATA_W];
      dstrm_bvalid <= rx_flit[BVALID_LSB +: BVALID_W];
      dstrm_valid  <= rx_flit[VALID_LSB];
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Lanes come from one word clock, so markers and strobes agree
  a_lanes_aligned: assert property (@(posedge clk_wr) disable iff (rst)
    rx_online_delay |->
      ((lane_mrk == '0) || (lane_mrk == '1)) &&
      ((lane_stb == '0) || (lane_stb == '1)));

endmodule

// ==== verilog/lpif_slave_top.sv ====
`timescale 1ns/10ps

module lpif_slave_top #(
  parameter int NUM_LANES     = 4,
  parameter int STROBE_PERIOD = lpif_pkg::STROBE_PERIOD_DEF
) (
  input  logic                                  clk_wr,
  input  logic                                  rst,

  // Link control
  input  logic                                  tx_online,
  input  logic                                  rx_online,
  input  logic [lpif_pkg::DELAY_W-1:0]          delay_x_value,
  input  logic [lpif_pkg::DELAY_W-1:0]          delay_xz_value,
  input  logic [lpif_pkg::DELAY_W-1:0]          delay_yz_value,

  // Upstream channel
  input  logic [lpif_pkg::STATE_W-1:0]          ustrm_state,
  input  logic [lpif_pkg::PROTID_W-1:0]         ustrm_protid,
  input  logic [lpif_pkg::DATA_W-1:0]           ustrm_data,
  input  logic [lpif_pkg::BVALID_W-1:0]         ustrm_bvalid,
  input  logic                                  ustrm_valid,

  // PHY lanes
  output logic [NUM_LANES*lpif_pkg::LANE_W-1:0] tx_phy,
  input  logic [NUM_LANES*lpif_pkg::LANE_W-1:0] rx_phy,

  // Downstream channel
  output logic [lpif_pkg::STATE_W-1:0]          dstrm_state,
  output logic [lpif_pkg::PROTID_W-1:0]         dstrm_protid,
  output logic [lpif_pkg::DATA_W-1:0]           dstrm_data,
  output logic [lpif_pkg::BVALID_W-1:0]         dstrm_bvalid,
  output logic                                  dstrm_valid
);

  //////////////////////////////
  // Internal wires
  //////////////////////////////

  logic tx_online_delay;
  logic rx_online_delay;
  logic tx_auto_mrk_userbit;
  logic tx_auto_stb_userbit;

  //////////////////////////////
  // Auto sync
  //////////////////////////////

  link_auto_sync #(
    .STROBE_PERIOD        (STROBE_PERIOD)
  ) u_auto_sync (
    .clk_wr               (clk_wr),
    .rst                  (rst),
    .tx_online            (tx_online),
    .rx_online            (rx_online),
    .delay_x_value        (delay_x_value),
    .delay_xz_value       (delay_xz_value),
    .delay_yz_value       (delay_yz_value),
    .tx_online_delay      (tx_online_delay),
    .rx_online_delay      (rx_online_delay),
    .tx_auto_mrk_userbit  (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit  (tx_auto_stb_userbit)
  );

  //////////////////////////////
  // Transmit packer
  //////////////////////////////

  // Marker and strobe come only from auto sync
  lpif_tx_lane_packer #(
    .NUM_LANES            (NUM_LANES)
  ) u_tx_packer (
    .clk_wr               (clk_wr),
    .rst                  (rst),
    .tx_online_delay      (tx_online_delay),
    .tx_mrk_userbit       (tx_auto_mrk_userbit),
    .tx_stb_userbit       (tx_auto_stb_userbit),
    .ustrm_state          (ustrm_state),
    .ustrm_protid         (ustrm_protid),
    .ustrm_data           (ustrm_data),
    .ustrm_bvalid         (ustrm_bvalid),
    .ustrm_valid          (ustrm_valid),
    .tx_phy               (tx_phy)
  );

  //////////////////////////////
  // Receive unpacker
  //////////////////////////////

  lpif_rx_lane_unpacker #(
    .NUM_LANES            (NUM_LANES)
  ) u_rx_unpacker (
    .clk_wr               (clk_wr),
    .rst                  (rst),
    .rx_online_delay      (rx_online_delay),
    .rx_phy               (rx_phy),
    .dstrm_state          (dstrm_state),
    .dstrm_protid         (dstrm_protid),
    .dstrm_data           (dstrm_data),
    .dstrm_bvalid         (dstrm_bvalid),
    .dstrm_valid          (dstrm_valid)
  );

endmodule

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 3
) (
  output logic clk_wr,
  output logic rst
);

  initial begin
    clk_wr = 1'b0;
    forever #(PERIOD_NS / 2) clk_wr = ~clk_wr;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_wr);
    @(negedge clk_wr);
    rst = 1'b0;
  end

endmodule

// ==== tests/tb_lpif_slave_top.sv ====
`timescale 1ns/10ps

module tb_lpif_slave_top;

  import lpif_pkg::*;

  localparam int NUM_LANES     = 4;
  localparam int STROBE_PERIOD = STROBE_PERIOD_DEF;
  localparam int PHY_W         = NUM_LANES * LANE_W;
  localparam int WAIT_LIMIT    = 200;

  logic                clk_wr;
  logic                rst;
  logic                tx_online;
  logic                rx_online;
  logic [DELAY_W-1:0]  delay_x_value;
  logic [DELAY_W-1:0]  delay_xz_value;
  logic [DELAY_W-1:0]  delay_yz_value;
  logic [STATE_W-1:0]  ustrm_state;
  logic [PROTID_W-1:0] ustrm_protid;
  logic [DATA_W-1:0]   ustrm_data;
  logic [BVALID_W-1:0] ustrm_bvalid;
  logic                ustrm_valid;
  logic [PHY_W-1:0]    tx_phy;
  logic [PHY_W-1:0]    rx_phy;
  logic [STATE_W-1:0]  dstrm_state;
  logic [PROTID_W-1:0] dstrm_protid;
  logic [DATA_W-1:0]   dstrm_data;
  logic [BVALID_W-1:0] dstrm_bvalid;
  logic                dstrm_valid;
  logic [FLIT_W-1:0]   ustrm_flit;

  // Cycle model state
  int                  m_tx_seen;
  int                  m_rx_seen;
  int                  m_on_idx;
  logic                m_tx_dly;
  logic                m_rx_dly;
  logic                m_mrk;
  logic                m_stb;
  logic [PHY_W-1:0]    m_phy;
  logic [FLIT_W-1:0]   m_phy_flit;
  logic [FLIT_W-1:0]   m_dstrm;
  bit                  model_ready = 1'b0;

  logic [31:0]         seed = 32'd94;
  int                  lane_err = 0;
  int                  flit_err = 0;
  int                  level_err = 0;
  int                  timing_err = 0;
  int                  timeout_err = 0;

  tb_clk_gen #(
    .PERIOD_NS  (20),
    .RST_CYCLES (3)
  ) u_clk_gen (
    .clk_wr     (clk_wr),
    .rst        (rst)
  );

  // PHY loopback
  assign rx_phy = tx_phy;

  lpif_slave_top #(
    .NUM_LANES     (NUM_LANES),
    .STROBE_PERIOD (STROBE_PERIOD)
  ) u_lpif_slave_top (.*);

  // Valid at the LSB, state at the top
  assign ustrm_flit = {ustrm_state, ustrm_protid, ustrm_data, ustrm_bvalid, ustrm_valid};

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // Lane k takes flit bits from k*22 upward, marker on top, strobe below it
  function automatic logic [PHY_W-1:0] lane_words(input logic [FLIT_W-1:0] flit,
                                                  input logic mrk, input logic stb);
    logic [NUM_LANES*LANE_PAYLOAD_W-1:0] padded;
    logic [PHY_W-1:0]                    words;
    padded = '0;
    padded[FLIT_W-1:0] = flit;
    for (int k = 0; k < NUM_LANES; k++) begin
      words[k*LANE_W +: LANE_W] = {mrk, stb, padded[k*LANE_PAYLOAD_W +: LANE_PAYLOAD_W]};
    end
    return words;
  endfunction

  task automatic check_lane_word(input string name, input logic [PHY_W-1:0] got,
                                 input logic [PHY_W-1:0] exp);
    if (got !== exp) begin
      lane_err++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      level_err++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flit(input logic [STATE_W-1:0] state, input logic [PROTID_W-1:0] protid,
                            input logic [DATA_W-1:0] data, input logic [BVALID_W-1:0] bvalid,
                            input logic valid, input logic [FLIT_W-1:0] exp);
    logic [STATE_W-1:0]  e_state;
    logic [PROTID_W-1:0] e_protid;
    logic [DATA_W-1:0]   e_data;
    logic [BVALID_W-1:0] e_bvalid;
    logic                e_valid;
    {e_state, e_protid, e_data, e_bvalid, e_valid} = exp;
    if ({state, protid, data, bvalid} !== {e_state, e_protid, e_data, e_bvalid}) begin
      flit_err++;
      $display("Mismatch dstrm_state %h/%h dstrm_protid %h/%h at %0t",
               state, e_state, protid, e_protid, $time);
      $display("Mismatch dstrm_data %h/%h dstrm_bvalid %h/%h (got/expected)",
               data, e_data, bvalid, e_bvalid);
    end
    check_level("dstrm_valid", valid, e_valid);
  endtask

  //////////////////////////////
  // Cycle model and checker
  //////////////////////////////

  always @(posedge clk_wr) begin : model_step
    logic nxt_tx;
    logic nxt_rx;
    if (rst) begin
      m_tx_seen   = 0;
      m_rx_seen   = 0;
      m_on_idx    = 0;
      m_tx_dly    = 1'b0;
      m_rx_dly    = 1'b0;
      m_mrk       = 1'b0;
      m_stb       = 1'b0;
      m_phy       = '0;
      m_phy_flit  = '0;
      m_dstrm     = '0;
      model_ready = 1'b1;
    end else begin
      // Pipeline stages use last cycle's levels
      m_dstrm    = m_rx_dly ? m_phy_flit : '0;
      m_phy      = m_tx_dly ? lane_words(ustrm_flit, m_mrk, m_stb) : '0;
      m_phy_flit = m_tx_dly ? ustrm_flit : '0;
      // Delays count consecutive online samples
      nxt_tx    = tx_online && (m_tx_seen >= int'(delay_xz_value) + int'(delay_yz_value));
      m_tx_seen = tx_online ? m_tx_seen + 1 : 0;
      nxt_rx    = rx_online && (m_rx_seen >= int'(delay_x_value));
      m_rx_seen = rx_online ? m_rx_seen + 1 : 0;
      // Index 0 is the first online cycle
      m_on_idx  = (nxt_tx && m_tx_dly) ? m_on_idx + 1 : 0;
      m_mrk     = nxt_tx && (m_on_idx % 2 == 0);
      m_stb     = nxt_tx && (m_on_idx % STROBE_PERIOD == 0);
      m_tx_dly  = nxt_tx;
      m_rx_dly  = nxt_rx;
    end
  end

  always @(negedge clk_wr) begin
    if (model_ready) begin
      check_lane_word("tx_phy", tx_phy, m_phy);
      check_level("tx_phy lane 0 marker", tx_phy[MRK_BIT], m_phy[MRK_BIT]);
      check_level("tx_phy lane 0 strobe", tx_phy[STB_BIT], m_phy[STB_BIT]);
      check_flit(dstrm_state, dstrm_protid, dstrm_data, dstrm_bvalid, dstrm_valid, m_dstrm);
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // New random flit on every falling edge
  task automatic next_cycle();
    logic [95:0] bits;
    logic [31:0] rnd;
    @(negedge clk_wr);
    for (int i = 0; i < 6; i++) begin
      rnd = lcg_next();
      bits[i*16 +: 16] = rnd[31:16];
    end
    {ustrm_state, ustrm_protid, ustrm_data, ustrm_bvalid, ustrm_valid} = bits[FLIT_W-1:0];
  endtask

  task automatic run_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic wait_reset_done();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_wr);
      cycles++;
    end while (rst !== 1'b0 && cycles < WAIT_LIMIT);
    if (rst !== 1'b0) begin
      timeout_err++;
      $display("Timeout: reset still asserted after %0d cycles", cycles);
    end
  endtask

  task automatic wait_first_strobe(input int expected);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < WAIT_LIMIT) begin
      next_cycle();
      if (tx_phy[STB_BIT] === 1'b1) seen = 1'b1;
      else cycles++;
    end
    if (!seen) begin
      timeout_err++;
      $display("Timeout: no strobe on tx_phy within %0d cycles", WAIT_LIMIT);
    end else if (cycles != expected) begin
      timing_err++;
      $display("First tx strobe came after %0d cycles instead of %0d", cycles, expected);
    end
  endtask

  task automatic wait_first_data(input int expected);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < WAIT_LIMIT) begin
      next_cycle();
      if ({dstrm_state, dstrm_protid, dstrm_data, dstrm_bvalid, dstrm_valid} != '0) seen = 1'b1;
      else cycles++;
    end
    if (!seen) begin
      timeout_err++;
      $display("Timeout: downstream flit stayed zero for %0d cycles", WAIT_LIMIT);
    end else if (cycles != expected) begin
      timing_err++;
      $display("First downstream flit came after %0d cycles instead of %0d", cycles, expected);
    end
  endtask

  initial begin : main_seq
    logic [31:0] rnd;
    int          tx_lat;
    int          rx_lat;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_x_value  = '0;
    delay_xz_value = '0;
    delay_yz_value = '0;
    ustrm_state    = '0;
    ustrm_protid   = '0;
    ustrm_data     = '0;
    ustrm_bvalid   = '0;
    ustrm_valid    = 1'b0;
    wait_reset_done();
    // Both sides offline, outputs must stay zero
    run_cycles(6);
    for (int round = 0; round < 3; round++) begin
      rnd            = lcg_next();
      delay_x_value  = DELAY_W'(rnd[19:16]);
      delay_xz_value = DELAY_W'(rnd[23:20]);
      delay_yz_value = DELAY_W'(rnd[27:24]);
      tx_lat = int'(delay_xz_value) + int'(delay_yz_value) + 1;
      rx_lat = int'(delay_x_value) + 1;
      $display("Round %0d: delay_x %0d delay_xz %0d delay_yz %0d",
               round, delay_x_value, delay_xz_value, delay_yz_value);
      tx_online = 1'b1;
      wait_first_strobe(tx_lat);
      rx_online = 1'b1;
      wait_first_data(rx_lat);
      run_cycles(3 * STROBE_PERIOD);
      // Tx drop while rx keeps running
      tx_online = 1'b0;
      run_cycles(6);
      tx_online = 1'b1;
      wait_first_strobe(tx_lat);
      run_cycles(STROBE_PERIOD + 5);
      // Rx drop while tx keeps running
      rx_online = 1'b0;
      run_cycles(6);
      rx_online = 1'b1;
      wait_first_data(rx_lat);
      run_cycles(STROBE_PERIOD + 5);
      tx_online = 1'b0;
      rx_online = 1'b0;
      run_cycles(4);
    end
    $display("Errors: lane_word %0d, flit %0d, level %0d, timing %0d, timeout %0d",
             lane_err, flit_err, level_err, timing_err, timeout_err);
    if (lane_err + flit_err + level_err + timing_err + timeout_err == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/lpif_pkg.sv
verilog/link_auto_sync.sv
verilog/lpif_tx_lane_packer.sv
verilog/lpif_rx_lane_unpacker.sv
verilog/lpif_slave_top.sv
tests/tb_clk_gen.sv
tests/tb_lpif_slave_top.sv
